//--- Bender.yml
package:
  name: led_strand

sources:
  - files:
      - hdl/led_pkg.sv
      - hdl/led_regs.sv
      - hdl/pixel_ram.sv
      - hdl/frame_fetch.sv
      - hdl/led_driver.sv
      - hdl/led_strand_top.sv
  - target: test
    files:
      - tb/led_strand_assertions.sv
      - tb/led_strand_tb.sv

//--- hdl/frame_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module frame_fetch (
    input  logic                          clk_in,
    input  logic                          force_reset,
    input  logic [led_pkg::led_idx_w-1:0] strand_len,
    input  logic [7:0]                    brightness,
    input  logic                          refresh_start,
    input  logic                          busy,
    input  logic                          pixel_req,
    output logic                          rd_en,
    output logic [led_pkg::led_idx_w-2:0] rd_addr,
    input  led_pkg::pixel_word_u          rd_data,
    output led_pkg::pixel_word_u          pixel,
    output logic                          pixel_valid
);
    import led_pkg::*;

    logic [led_idx_w-1:0] idx;        // next led to read
    logic                 frame_on;
    logic                 busy_q;
    logic                 rd_pend;    // rd_data valid this cycle
    logic                 start_ok;
    logic                 fetch_ok;
    pixel_word_u          scaled;

    // channel * (brightness + 1) / 256
    function automatic logic [color_w-1:0] scale_chan(input logic [color_w-1:0] chan,
                                                      input logic [7:0] bright);
        logic [16:0] prod;
        prod = chan * ({1'b0, bright} + 9'd1);
        return prod[15:8];
    endfunction

    assign start_ok = refresh_start && !busy && !frame_on && (strand_len != '0);
    assign fetch_ok = pixel_req && frame_on && (idx < strand_len);

    assign rd_en   = start_ok || fetch_ok;
    assign rd_addr = start_ok ? '0 : idx[led_idx_w-2:0];

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            scaled.bytes[i] = scale_chan(rd_data.bytes[i], brightness);
        end
    end

    always_ff @(posedge clk_in) begin
        if (force_reset) begin
            idx         <= '0;
            frame_on    <= 1'b0;
            busy_q      <= 1'b0;
            rd_pend     <= 1'b0;
            pixel_valid <= 1'b0;
        end else begin
            busy_q      <= busy;
            rd_pend     <= rd_en;
            pixel_valid <= rd_pend;
            if (start_ok) begin
                idx      <= led_idx_w'(1);  // led 0 read now
                frame_on <= 1'b1;
            end else if (fetch_ok) begin
                idx <= idx + 1'b1;
            end else if (busy_q && !busy) begin
                frame_on <= 1'b0;  // driver finished latch
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rd_pend) begin
            pixel <= scaled;
        end
    end

endmodule

`default_nettype wire

//--- hdl/led_driver.sv
`timescale 1ns/10ps
`default_nettype none

module led_driver (
    input  logic                 clk_in,
    input  logic                 force_reset,
    input  led_pkg::pixel_word_u pixel,
    input  logic                 pixel_valid,
    output logic                 pixel_req,
    output logic                 strand,
    output logic                 busy,
    output logic                 frame_done
);
    import led_pkg::*;

    logic [1:0]       state;
    pixel_word_u      shift_word;   // msb is the bit on the line
    pixel_word_u      next_word;    // one deep buffer
    logic             next_full;
    logic [bit_w-1:0] bit_cnt;
    logic [cyc_w-1:0] cyc_cnt;      // cycles into bit or latch

    logic             cur_bit;
    logic [cyc_w-1:0] high_last;
    logic [cyc_w-1:0] bit_last;
    logic             high_end;
    logic             bit_end;
    logic             word_end;
    logic             latch_end;

    assign cur_bit = shift_word.raw[pixel_w-1];

    // last cycle of the high part and of the whole bit
    assign high_last = cur_bit ? cyc_w'(t1h_cyc - 1) : cyc_w'(t0h_cyc - 1);
    assign bit_last  = cur_bit ? cyc_w'(t1h_cyc + t1l_cyc - 1)
                               : cyc_w'(t0h_cyc + t0l_cyc - 1);

    assign high_end  = (cyc_cnt == high_last);
    assign bit_end   = (cyc_cnt == bit_last);
    assign word_end  = bit_end && (bit_cnt == bit_w'(pixel_w - 1));
    assign latch_end = (cyc_cnt == cyc_w'(res_cyc - 1));

    assign busy = (state != st_idle);

    always_ff @(posedge clk_in) begin
        if (force_reset) begin
            state      <= st_idle;
            strand     <= 1'b0;
            pixel_req  <= 1'b0;
            frame_done <= 1'b0;
            next_full  <= 1'b0;
            bit_cnt    <= '0;
            cyc_cnt    <= '0;
        end else begin
            pixel_req  <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                st_idle: begin
                    next_full <= 1'b0;
                    if (pixel_valid) begin
                        shift_word <= pixel;
                        strand     <= 1'b1;  // first bit starts next cycle
                        pixel_req  <= 1'b1;
                        bit_cnt    <= '0;
                        cyc_cnt    <= '0;
                        state      <= st_send;
                    end
                end

                st_send: begin
                    cyc_cnt <= cyc_cnt + 1'b1;

                    // fetch answers arrive while the word is on the line
                    if (pixel_valid) begin
                        next_word <= pixel;
                        next_full <= 1'b1;
                    end

                    if (high_end) begin
                        strand <= 1'b0;
                    end

                    if (word_end) begin
                        cyc_cnt <= '0;
                        bit_cnt <= '0;
                        if (next_full) begin
                            shift_word <= next_word;
                            next_full  <= 1'b0;
                            strand     <= 1'b1;
                            pixel_req  <= 1'b1;
                        end else begin
                            strand <= 1'b0;
                            state  <= st_latch;  // strand ran out
                        end
                    end else if (bit_end) begin
                        shift_word.raw <= {shift_word.raw[pixel_w-2:0], 1'b0};
                        bit_cnt        <= bit_cnt + 1'b1;
                        cyc_cnt        <= '0;
                        strand         <= 1'b1;
                    end
                end

                st_latch: begin
                    // line held low, leds take their new colours
                    cyc_cnt <= cyc_cnt + 1'b1;
                    if (latch_end) begin
                        cyc_cnt    <= '0;
                        frame_done <= 1'b1;
                        state      <= st_idle;  // busy drops with frame_done
                    end
                end

                default: begin
                    strand <= 1'b0;
                    state  <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/led_pkg.sv
`default_nettype none

package led_pkg;

    // system clock, 8 ns period
    localparam longint clock_hz = 125_000_000;

    // strand and pixel sizes
    localparam int num_leds  = 16;
    localparam int led_idx_w = $clog2(num_leds) + 1;  // holds 0..num_leds
    localparam int color_w   = 8;
    localparam int pixel_w   = 3 * color_w;
    localparam int bit_w     = $clog2(pixel_w);        // bit index within a pixel

    // datasheet times converted to cycles, truncated
    localparam int t0h_cyc = int'(longint'(400) * clock_hz / 1_000_000_000);
    localparam int t0l_cyc = int'(longint'(850) * clock_hz / 1_000_000_000);
    localparam int t1h_cyc = int'(longint'(800) * clock_hz / 1_000_000_000);
    localparam int t1l_cyc = int'(longint'(450) * clock_hz / 1_000_000_000);
    localparam int res_cyc = int'(longint'(50_000) * clock_hz / 1_000_000_000);

    // the latch period is the longest count
    localparam int cyc_w = $clog2(res_cyc + 1);

    // host configuration map
    localparam logic [1:0] cfg_len_addr    = 2'd0;
    localparam logic [1:0] cfg_bright_addr = 2'd1;
    localparam logic [1:0] cfg_start_addr  = 2'd2;

    // serializer states
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_send  = 2'd1;
    localparam logic [1:0] st_latch = 2'd2;

    // one pixel, seen as a shift word or as three channels
    // bytes[2] green, bytes[1] red, bytes[0] blue
    typedef union packed {
        logic [pixel_w-1:0]             raw;
        logic [2:0][color_w-1:0]        bytes;
    } pixel_word_u;

endpackage

`default_nettype wire

//--- hdl/led_regs.sv
`timescale 1ns/10ps
`default_nettype none

module led_regs (
    input  logic                          clk_in,
    input  logic                          force_reset,
    input  logic                          cfg_wr,
    input  logic [1:0]                    cfg_addr,
    input  logic [7:0]                    cfg_wdata,
    output logic [led_pkg::led_idx_w-1:0] strand_len,
    output logic [7:0]                    brightness,
    output logic                          refresh_start
);
    import led_pkg::*;

    logic                 len_wr;
    logic                 bright_wr;
    logic                 start_wr;
    logic [led_idx_w-1:0] len_clamped;

    // address decode
    assign len_wr    = cfg_wr && (cfg_addr == cfg_len_addr);
    assign bright_wr = cfg_wr && (cfg_addr == cfg_bright_addr);
    assign start_wr  = cfg_wr && (cfg_addr == cfg_start_addr);  // data ignored

    // lengths beyond the memory are cut to the memory depth
    always_comb begin
        if (cfg_wdata > 8'(num_leds)) begin
            len_clamped = led_idx_w'(num_leds);
        end else begin
            len_clamped = cfg_wdata[led_idx_w-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (force_reset) begin
            strand_len    <= '0;
            brightness    <= 8'hff;  // full scale
            refresh_start <= 1'b0;
        end else begin
            refresh_start <= start_wr;  // single cycle strobe
            if (len_wr) begin
                strand_len <= len_clamped;
            end
            if (bright_wr) begin
                brightness <= cfg_wdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/led_strand_top.sv
`timescale 1ns/10ps
`default_nettype none

module led_strand_top (
    input  logic                          clk_in,
    input  logic                          force_reset,
    input  logic                          pix_wr,
    input  logic [led_pkg::led_idx_w-2:0] pix_addr,
    input  led_pkg::pixel_word_u          pix_data,
    input  logic                          cfg_wr,
    input  logic [1:0]                    cfg_addr,
    input  logic [7:0]                    cfg_wdata,
    output logic                          strand,
    output logic                          busy,
    output logic                          frame_done
);
    import led_pkg::*;

    logic [led_idx_w-1:0] strand_len;
    logic [7:0]           brightness;
    logic                 refresh_start;
    logic                 rd_en;
    logic [led_idx_w-2:0] rd_addr;
    pixel_word_u          rd_data;
    pixel_word_u          pixel;
    logic                 pixel_valid;
    logic                 pixel_req;

    led_regs u_regs (
        .clk_in        (clk_in),
        .force_reset   (force_reset),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .strand_len    (strand_len),
        .brightness    (brightness),
        .refresh_start (refresh_start)
    );

    pixel_ram u_ram (
        .clk_in   (clk_in),
        .pix_wr   (pix_wr),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    frame_fetch u_fetch (
        .clk_in        (clk_in),
        .force_reset   (force_reset),
        .strand_len    (strand_len),
        .brightness    (brightness),
        .refresh_start (refresh_start),
        .busy          (busy),
        .pixel_req     (pixel_req),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .pixel         (pixel),
        .pixel_valid   (pixel_valid)
    );

    led_driver u_driver (
        .clk_in      (clk_in),
        .force_reset (force_reset),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .pixel_req   (pixel_req),
        .strand      (strand),
        .busy        (busy),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire

//--- hdl/pixel_ram.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_ram (
    input  logic                          clk_in,
    input  logic                          pix_wr,
    input  logic [led_pkg::led_idx_w-2:0] pix_addr,
    input  led_pkg::pixel_word_u          pix_data,
    input  logic                          rd_en,
    input  logic [led_pkg::led_idx_w-2:0] rd_addr,
    output led_pkg::pixel_word_u          rd_data
);
    import led_pkg::*;

    // one word per led, keeps its contents through reset
    pixel_word_u mem [num_leds];

    // host side
    always_ff @(posedge clk_in) begin
        if (pix_wr) begin
            mem[pix_addr] <= pix_data;
        end
    end

    // sequencer side, one cycle latency
    always_ff @(posedge clk_in) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- tb/led_strand_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module led_strand_assertions (
    input logic clk_in,
    input logic force_reset,
    input logic strand,
    input logic busy,
    input logic frame_done
);
    import led_pkg::*;

    // a 1 bit has the longest high time on the line
    high_time_limit: assert property (
        @(posedge clk_in) disable iff (force_reset)
        $rose(strand) |-> ##[1:t1h_cyc] !strand
    ) else $error("strand high for more than %0d cycles", t1h_cyc);

    idle_line_low: assert property (
        @(posedge clk_in) disable iff (force_reset)
        !busy |-> !strand
    ) else $error("strand high while the driver is idle");

    done_one_cycle: assert property (
        @(posedge clk_in) disable iff (force_reset)
        frame_done |=> !frame_done
    ) else $error("frame_done longer than one cycle");

    // end of latch and drop of busy in the same cycle
    done_with_busy: assert property (
        @(posedge clk_in) disable iff (force_reset)
        (frame_done || $fell(busy)) |-> (frame_done && $fell(busy))
    ) else $error("frame_done and falling busy out of step");

endmodule

`default_nettype wire

//--- tb/led_strand_tb.sv
`timescale 1ns/10ps
`default_nettype none

module led_strand_tb;
    import led_pkg::*;

    localparam int clk_period = 8;
    localparam int num_frames = 6;
    localparam int frame_cyc  = num_leds * pixel_w * 156 + res_cyc + 20;  // worst case
    localparam int rise_delay = 4 * clk_period + clk_period / 2;  // seen on the falling edge

    logic                 clk_in;
    logic                 force_reset;
    logic                 pix_wr;
    logic [led_idx_w-2:0] pix_addr;
    pixel_word_u          pix_data;
    logic                 cfg_wr;
    logic [1:0]           cfg_addr;
    logic [7:0]           cfg_wdata;
    logic                 strand;
    logic                 busy;
    logic                 frame_done;

    logic [pixel_w-1:0] colors [num_leds];  // host copy of the pixel memory
    logic [pixel_w-1:0] exp_q [$];
    logic [pixel_w-1:0] got_q [$];
    logic [pixel_w-1:0] got_word;
    logic [pixel_w-1:0] exp_word;
    logic [pixel_w-1:0] rnd;
    logic [15:0]        lfsr;
    int                 errors;
    longint             wr_time;
    longint             start_time;
    bit                 expect_start;
    int                 frame_words;

    // line decoder state
    logic               line_q;
    logic               busy_q;
    logic               in_frame;
    logic               pend;          // bit seen, low time not yet over
    logic               cur_bit;
    int                 high_run;
    int                 low_run;
    int                 bit_cnt;
    int                 word_cnt;
    logic [pixel_w-1:0] shift_in;

    led_strand_top u_dut (
        .clk_in      (clk_in),
        .force_reset (force_reset),
        .pix_wr      (pix_wr),
        .pix_addr    (pix_addr),
        .pix_data    (pix_data),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .strand      (strand),
        .busy        (busy),
        .frame_done  (frame_done)
    );

    bind led_driver led_strand_assertions u_sva (
        .clk_in      (clk_in),
        .force_reset (force_reset),
        .strand      (strand),
        .busy        (busy),
        .frame_done  (frame_done)
    );

    initial begin
        clk_in = 1'b0;
        forever #(clk_period / 2) clk_in = ~clk_in;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [pixel_w-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[pixel_w-2:0], lfsr[0]};
        end
    endtask

    // each channel times (brightness + 1), divided by 256
    function automatic logic [pixel_w-1:0] scaled_pixel(input logic [pixel_w-1:0] color,
                                                        input logic [7:0] bright);
        logic [pixel_w-1:0] result;
        int unsigned        prod;
        for (int k = 0; k < 3; k++) begin
            prod = color[k*color_w +: color_w] * (bright + 1);
            result[k*color_w +: color_w] = prod >> 8;
        end
        return result;
    endfunction

    function automatic int low_time(input logic b);
        return b ? t1l_cyc : t0l_cyc;
    endfunction

    task automatic report_mismatch(input string sig, input longint got, input longint want);
        errors++;
        $display("FAILED time %0t: %s got 0x%0h expected 0x%0h", $time, sig, got, want);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR time %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk_in);
        wr_time = $time;
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk_in);
        cfg_wr <= 1'b0;
    endtask

    task automatic pix_write(input logic [led_idx_w-2:0] addr, input logic [pixel_w-1:0] color);
        @(posedge clk_in);
        pix_wr       <= 1'b1;
        pix_addr     <= addr;
        pix_data.raw <= color;
        @(posedge clk_in);
        pix_wr <= 1'b0;
    endtask

    task automatic wait_frame_done();
        @(negedge clk_in);
        while (!frame_done) @(negedge clk_in);
    endtask

    task automatic quiet_window(input int cycles);
        repeat (cycles) begin
            @(negedge clk_in);
            assert (!strand && !busy && !frame_done)
                else report_error("strand activity after an ignored start");
        end
    endtask

    // one refresh; restart sends a second start while the frame is running
    task automatic run_frame(input logic [7:0] len_cfg, input logic [7:0] bright,
                             input int words, input bit restart);
        cfg_write(cfg_len_addr, len_cfg);
        cfg_write(cfg_bright_addr, bright);
        for (int i = 0; i < words; i++) begin
            exp_q.push_back(scaled_pixel(colors[i], bright));
        end
        frame_words  = words;
        expect_start = 1'b1;
        cfg_write(cfg_start_addr, 8'h00);
        start_time = wr_time;
        if (restart) begin
            @(negedge clk_in);
            while (!busy) @(negedge clk_in);
            cfg_write(cfg_start_addr, 8'h5a);
        end
        wait_frame_done();
    endtask

    // rebuilds bits and words from the high and low runs on the line
    always @(negedge clk_in) begin
        if (force_reset) begin
            line_q   = 1'b0;
            busy_q   = 1'b0;
            in_frame = 1'b0;
            pend     = 1'b0;
            cur_bit  = 1'b0;
            high_run = 0;
            low_run  = 0;
            bit_cnt  = 0;
            word_cnt = 0;
            shift_in = '0;
        end else begin
            if (strand && !line_q) begin
                if (in_frame) begin
                    assert (!pend && low_run == low_time(cur_bit))
                        else report_mismatch("strand low time", low_run, low_time(cur_bit));
                end else begin
                    assert (expect_start) else report_error("strand rose without a start");
                    assert ($time - start_time == rise_delay)
                        else report_mismatch("strand rise delay", $time - start_time, rise_delay);
                    expect_start = 1'b0;
                    in_frame     = 1'b1;
                    word_cnt     = 0;
                    bit_cnt      = 0;
                end
                high_run = 0;
            end
            if (!strand && line_q) begin
                assert (high_run == t0h_cyc || high_run == t1h_cyc)
                    else report_error($sformatf("high run of %0d cycles is no bit", high_run));
                cur_bit = (high_run == t1h_cyc);
                pend    = 1'b1;
                low_run = 0;
            end
            if (strand) high_run++;
            else low_run++;
            if (pend && low_run == low_time(cur_bit)) begin
                shift_in = {shift_in[pixel_w-2:0], cur_bit};
                pend     = 1'b0;
                bit_cnt++;
                if (bit_cnt == pixel_w) begin
                    got_q.push_back(shift_in);
                    bit_cnt = 0;
                    word_cnt++;
                end
            end
            if (frame_done) begin
                assert (in_frame) else report_error("frame_done without a frame on the strand");
                assert (word_cnt == frame_words)
                    else report_mismatch("frame word count", word_cnt, frame_words);
                assert (bit_cnt == 0 && !pend) else report_error("frame ended inside a pixel");
                assert (low_run >= low_time(cur_bit) + res_cyc)
                    else report_error("latch low time shorter than res_cyc");
                assert (busy_q && !busy) else report_error("busy did not fall with frame_done");
                in_frame = 1'b0;
            end
            line_q = strand;
            busy_q = busy;
        end
    end

    always @(negedge clk_in) begin
        if (got_q.size() != 0) begin
            got_word = got_q.pop_front();
            assert (exp_q.size() != 0) else report_error("decoded a word nobody expected");
            exp_word = exp_q.pop_front();
            assert (got_word == exp_word) else report_mismatch("strand word", got_word, exp_word);
        end
    end

    initial begin
        repeat (num_frames * frame_cyc + 20_000) @(posedge clk_in);
        $display("ERROR: watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        force_reset  = 1'b1;
        pix_wr       = 1'b0;
        pix_addr     = '0;
        pix_data     = '0;
        cfg_wr       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        errors       = 0;
        lfsr         = 16'd52929;
        expect_start = 1'b0;
        start_time   = 0;
        wr_time      = 0;
        frame_words  = 0;
        repeat (16) @(posedge clk_in);
        force_reset <= 1'b0;

        for (int i = 0; i < num_leds; i++) begin
            rand_bits(pixel_w, rnd);
            colors[i] = rnd;
            pix_write((led_idx_w-1)'(i), rnd);
        end

        run_frame(8'd5, 8'd255, 5, 1'b0);  // content at full scale
        run_frame(8'd3, 8'd0, 3, 1'b0);
        run_frame(8'd4, 8'd128, 4, 1'b0);
        rand_bits(8, rnd);
        run_frame(8'd16, rnd[7:0], 16, 1'b0);
        run_frame(8'd2, 8'd255, 2, 1'b1);  // extra start while busy
        quiet_window(200);

        // zero length, nothing may move
        cfg_write(cfg_len_addr, 8'd0);
        cfg_write(cfg_start_addr, 8'h01);
        quiet_window(200);

        run_frame(8'd200, 8'd255, num_leds, 1'b0);  // clamped to the memory depth

        repeat (10) @(posedge clk_in);
        assert (exp_q.size() == 0) else report_error("expected words never appeared");
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hdl/led_pkg.sv
hdl/led_regs.sv
hdl/pixel_ram.sv
hdl/frame_fetch.sv
hdl/led_driver.sv
hdl/led_strand_top.sv
tb/led_strand_assertions.sv
tb/led_strand_tb.sv
